/* build.f */
design/reg_apb_pkg.sv
design/apb_if.sv
design/reg_native_if2apb.sv
design/apb_decoder.sv
design/apb_reg_bank.sv
design/reg_apb_top.sv
sim/tb_reg_apb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the register subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f build.f \
    --top-module tb_reg_apb_top \
    -o sim_tb_reg_apb_top

./obj_dir/sim_tb_reg_apb_top

/* sim/tb_reg_apb_top.sv */
`timescale 1ns/10ps

module tb_reg_apb_top;

    localparam int ADDR_WIDTH  = 16;
    localparam int DATA_WIDTH  = 32;
    localparam int CLK_PERIOD  = 8;
    localparam int RST_CYCLES  = 8;
    localparam int NUM_WORDS   = 2 ** reg_apb_pkg::REG_IDX_BITS;

    // Ack latency in cycles after the edge that drives the request
    localparam int LAT_FAST    = 2;
    localparam int LAT_SLOW    = 4;
    localparam int MAX_WAIT    = 10;

    localparam int N_RAND      = 300;
    localparam int N_SOFT      = 4;
    localparam int N_SWEEPS    = 3;
    localparam int SOFT_WATCH  = 10;
    localparam int N_REQ_TOTAL = 2 * (NUM_WORDS - 1) + N_SWEEPS * 2 * NUM_WORDS
                                 + N_RAND + 2 * N_SOFT;
    localparam int WDOG_CYCLES = N_REQ_TOTAL * 20 + RST_CYCLES;

    localparam logic [31:0] LFSR_SEED = 32'h4abe6f10;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef struct packed {
        logic                   wr;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [DATA_WIDTH-1:0]  data;
    } req_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   req_vld;
    logic                   ack_vld;
    logic                   soft_rst;
    logic                   wr_en;
    logic                   rd_en;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [DATA_WIDTH-1:0]  wr_data;
    logic [DATA_WIDTH-1:0]  rd_data;
    logic                   err;

    logic [31:0]            lfsr = LFSR_SEED;
    logic [DATA_WIDTH-1:0]  model [0:1][0:NUM_WORDS-1];    // Both banks

    always #(CLK_PERIOD / 2) clk = ~clk;

    reg_apb_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) i_reg_apb_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_vld    (req_vld),
        .ack_vld    (ack_vld),
        .soft_rst   (soft_rst),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .addr       (addr),
        .wr_data    (wr_data),
        .rd_data    (rd_data),
        .err        (err)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] id_word(input logic bank);
        return {reg_apb_pkg::ID_BASE[31:8], 7'b0, bank};
    endfunction

    function automatic req_t make_req(input logic wr, input logic bank,
                                      input reg_apb_pkg::reg_idx_t idx,
                                      input logic [DATA_WIDTH-1:0] data);
        req_t r;
        r.wr   = wr;
        r.data = data;
        r.addr = '0;
        r.addr[reg_apb_pkg::BANK_BIT] = bank;
        r.addr[reg_apb_pkg::REG_IDX_LSB +: reg_apb_pkg::REG_IDX_BITS] = idx;
        return r;
    endfunction

    task automatic stop_on_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_data(input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s: got 0x%h, expected 0x%h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s: got %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERROR at %0t: %s: ack after %0d cycles, expected %0d",
                     $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // Expected response from the register map rules and the model
    task automatic predict(input req_t r, output int lat, output logic e_err,
                           output logic [DATA_WIDTH-1:0] e_rd, output bit chk_rd,
                           output bit wr_ok);
        logic                   mapped;
        logic                   bank;
        logic                   unaligned;
        reg_apb_pkg::reg_idx_t  idx;
        mapped    = (r.addr >> (reg_apb_pkg::BANK_BIT + 1)) == '0;
        bank      = r.addr[reg_apb_pkg::BANK_BIT];
        idx       = r.addr[reg_apb_pkg::REG_IDX_LSB +: reg_apb_pkg::REG_IDX_BITS];
        unaligned = |r.addr[reg_apb_pkg::REG_IDX_LSB-1:0];
        e_rd   = '0;
        wr_ok  = 1'b0;
        if (!mapped) begin
            lat    = LAT_FAST;
            e_err  = 1'b1;
            chk_rd = !r.wr;    // Unmapped reads give zero
        end else begin
            lat    = bank ? LAT_SLOW : LAT_FAST;
            e_err  = unaligned | (r.wr & (idx == '0));
            chk_rd = !r.wr && !e_err;
            wr_ok  = r.wr && !e_err;
            if (chk_rd) begin
                e_rd = (idx == '0) ? id_word(bank) : model[bank][idx];
            end
        end
    endtask

    task automatic gen_req(output req_t r);
        logic [3:0]             kind;
        logic                   bank;
        reg_apb_pkg::reg_idx_t  idx;
        int                     pos;
        kind = 4'(take_bits(4));
        bank = 1'(take_bits(1));
        idx  = reg_apb_pkg::reg_idx_t'(take_bits(reg_apb_pkg::REG_IDX_BITS));
        r    = make_req(1'(take_bits(1)), bank, idx, take_bits(DATA_WIDTH));
        case (kind)
            4'd0: begin
                pos = reg_apb_pkg::BANK_BIT + 1 + int'(take_bits(3));
                r.addr[pos] = 1'b1;    // Unmapped
            end
            4'd1: begin
                r.addr[0] = 1'b1;
                r.addr[1] = 1'(take_bits(1));
            end
            4'd2: begin
                r.wr = 1'b1;    // Write to the identity word
                r.addr[reg_apb_pkg::REG_IDX_LSB +: reg_apb_pkg::REG_IDX_BITS] = '0;
            end
            default: ;
        endcase
    endtask

    task automatic drive_request(input req_t r);
        req_vld <= 1'b1;
        wr_en   <= r.wr;
        rd_en   <= ~r.wr;
        addr    <= r.addr;
        wr_data <= r.data;
    endtask

    task automatic release_request();
        req_vld <= 1'b0;
        wr_en   <= 1'b0;
        rd_en   <= 1'b0;
    endtask

    // Called in the edge that drove r; may drive nxt into the ack cycle
    task automatic run_one(input req_t r, input bit b2b, input req_t nxt);
        int                     lat;
        logic                   e_err;
        logic [DATA_WIDTH-1:0]  e_rd;
        bit                     chk_rd;
        bit                     wr_ok;
        int                     n;
        bit                     got_ack;
        string                  what;
        predict(r, lat, e_err, e_rd, chk_rd, wr_ok);
        what = $sformatf("%s 0x%h", r.wr ? "write" : "read", r.addr);
        @(posedge clk);
        release_request();
        n       = 0;
        got_ack = 1'b0;
        while (!got_ack && n < MAX_WAIT) begin
            n++;
            @(negedge clk);
            got_ack = (ack_vld === 1'b1);
            if (!got_ack) begin
                @(posedge clk);
                if (b2b && n + 1 == lat) begin
                    drive_request(nxt);
                end
            end
        end
        check_latency(n, lat, what);
        check_flag(err, e_err, {what, " err"});
        if (chk_rd) begin
            check_data(rd_data, e_rd, {what, " rd_data"});
        end
        if (wr_ok) begin
            model[r.addr[reg_apb_pkg::BANK_BIT]]
                 [r.addr[reg_apb_pkg::REG_IDX_LSB +: reg_apb_pkg::REG_IDX_BITS]] = r.data;
        end
    endtask

    task automatic single_req(input req_t r);
        @(posedge clk);
        drive_request(r);
        run_one(r, 1'b0, r);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);
            check_flag(ack_vld, 1'b0, "ack_vld while idle");
        end
    endtask

    task automatic read_sweep();
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                single_req(make_req(1'b0, 1'(b), reg_apb_pkg::reg_idx_t'(i), '0));
            end
        end
    endtask

    task automatic fill_banks();
        for (int b = 0; b < 2; b++) begin
            for (int i = 1; i < NUM_WORDS; i++) begin
                single_req(make_req(1'b1, 1'(b), reg_apb_pkg::reg_idx_t'(i),
                                    take_bits(DATA_WIDTH)));
            end
        end
    endtask

    task automatic random_phase();
        req_t   cur;
        req_t   nxt;
        bit     b2b;
        gen_req(cur);
        @(posedge clk);
        drive_request(cur);
        for (int i = 0; i < N_RAND; i++) begin
            gen_req(nxt);
            b2b = (i < N_RAND - 1) && (take_bits(1) == 32'd1);
            run_one(cur, b2b, nxt);
            if (!b2b) begin
                idle_cycles(int'(take_bits(2)));
                if (i < N_RAND - 1) begin
                    @(posedge clk);
                    drive_request(nxt);
                end
            end
            cur = nxt;
        end
    endtask

    // Bank 1 transfer abandoned in its wait states
    task automatic soft_abort_phase();
        req_t                   r;
        reg_apb_pkg::reg_idx_t  idx;
        for (int k = 0; k < N_SOFT; k++) begin
            idx = reg_apb_pkg::reg_idx_t'(take_bits(reg_apb_pkg::REG_IDX_BITS));
            if (idx == '0) begin
                idx = 1;
            end
            r = make_req(~1'(k), 1'b1, idx, take_bits(DATA_WIDTH));
            @(posedge clk);
            drive_request(r);
            for (int n = 1; n <= SOFT_WATCH; n++) begin
                @(posedge clk);
                if (n == 1) begin
                    release_request();
                end
                if (n == 3) begin
                    soft_rst <= 1'b1;
                end
                if (n == 4) begin
                    soft_rst <= 1'b0;
                end
                @(negedge clk);
                check_flag(ack_vld, 1'b0, "ack_vld for abandoned transfer");
            end
            single_req(make_req(1'b0, 1'b1, idx, '0));    // Old value still there
        end
    endtask

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the requests did not complete in the allowed time");
        stop_on_failure();
    end

    initial begin
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                model[b][i] = '0;
            end
        end
        rst_n    <= 1'b0;
        req_vld  <= 1'b0;
        soft_rst <= 1'b0;
        wr_en    <= 1'b0;
        rd_en    <= 1'b0;
        addr     <= '0;
        wr_data  <= '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(ack_vld, 1'b0, "ack_vld after reset");
        read_sweep();
        fill_banks();
        read_sweep();
        random_phase();
        soft_abort_phase();
        read_sweep();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* design/reg_apb_top.sv */
`timescale 1ns/10ps

module reg_apb_top #(
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    req_vld,
    output logic                    ack_vld,
    input  logic                    soft_rst,
    input  logic                    wr_en,
    input  logic                    rd_en,
    input  logic [ADDR_WIDTH-1:0]   addr,
    input  logic [DATA_WIDTH-1:0]   wr_data,
    output logic [DATA_WIDTH-1:0]   rd_data,
    output logic                    err
);
    apb_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) bus_m  ();
    apb_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) bus_s0 ();
    apb_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) bus_s1 ();

    reg_native_if2apb #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) i_reg_native_if2apb (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_vld    (req_vld),
        .ack_vld    (ack_vld),
        .soft_rst   (soft_rst),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .addr       (addr),
        .wr_data    (wr_data),
        .rd_data    (rd_data),
        .err        (err),
        .apb        (bus_m.master)
    );

    apb_decoder #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) i_apb_decoder (
        .up         (bus_m.slave),
        .dn0        (bus_s0.master),
        .dn1        (bus_s1.master)
    );

    // Bank 0 answers without wait states
    apb_reg_bank #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .DATA_WIDTH  (DATA_WIDTH),
        .BANK_NUM    (0),
        .WAIT_CYCLES (0)
    ) i_apb_reg_bank0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .soft_rst    (soft_rst),
        .apb         (bus_s0.slave)
    );

    apb_reg_bank #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .DATA_WIDTH  (DATA_WIDTH),
        .BANK_NUM    (1),
        .WAIT_CYCLES (2)    // Slow bank
    ) i_apb_reg_bank1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .soft_rst    (soft_rst),
        .apb         (bus_s1.slave)
    );

endmodule

/* design/apb_reg_bank.sv */
`timescale 1ns/10ps

module apb_reg_bank #(
    parameter int ADDR_WIDTH  = 16,
    parameter int DATA_WIDTH  = 32,
    parameter int BANK_NUM    = 0,
    parameter int WAIT_CYCLES = 0
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    soft_rst,

    apb_if.slave    apb
);
    localparam int CNT_W     = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
    localparam int NUM_WORDS = 2 ** reg_apb_pkg::REG_IDX_BITS;

    // Identity word of this bank
    localparam logic [DATA_WIDTH-1:0] ID_WORD =
        DATA_WIDTH'({reg_apb_pkg::ID_BASE[31:8], 8'(BANK_NUM)});

    logic [ADDR_WIDTH-1:0]  paddr;
    reg_apb_pkg::reg_idx_t  idx;
    logic                   unaligned;
    logic                   acc_err;
    logic                   access;
    logic                   done;
    logic                   wr_fire;
    logic [CNT_W-1:0]       wait_cnt;
    logic [DATA_WIDTH-1:0]  regs [1:NUM_WORDS-1];
    logic [DATA_WIDTH-1:0]  rd_word;

    assign paddr     = apb.paddr;
    assign idx       = paddr[reg_apb_pkg::REG_IDX_LSB +: reg_apb_pkg::REG_IDX_BITS];
    assign unaligned = |paddr[reg_apb_pkg::REG_IDX_LSB-1:0];

    // Word 0 is read-only
    assign acc_err   = unaligned | (apb.pwrite & (idx == '0));

    assign access    = apb.psel & apb.penable;
    assign done      = access & (wait_cnt == CNT_W'(WAIT_CYCLES));
    assign wr_fire   = done & apb.pwrite & ~acc_err;

    // Counts wait states through the access phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (soft_rst || !apb.psel || done) begin
            wait_cnt <= '0;    // Idle, abandoned or finished
        end else if (access) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire) begin
            regs[idx] <= apb.pwdata;
        end
    end

    always_comb begin
        if (idx == '0) begin
            rd_word = ID_WORD;
        end else begin
            rd_word = regs[idx];
        end
    end

    // Read data only on a good read
    assign apb.prdata  = (done && !apb.pwrite && !acc_err) ? rd_word : '0;
    assign apb.pready  = done;
    assign apb.pslverr = done & acc_err;

endmodule

/* design/apb_decoder.sv */
`timescale 1ns/10ps

module apb_decoder #(
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32
) (
    apb_if.slave    up,
    apb_if.master   dn0,
    apb_if.master   dn1
);
    localparam int HI_LSB = reg_apb_pkg::BANK_BIT + 1;

    logic mapped;
    logic bank_sel;
    logic err_rsp;

    // Anything above the bank bit is unmapped space
    assign mapped   = (up.paddr[ADDR_WIDTH-1:HI_LSB] == '0);
    assign bank_sel = up.paddr[reg_apb_pkg::BANK_BIT];

    // Unmapped access answers at once
    assign err_rsp  = up.psel & up.penable & ~mapped;

    assign dn0.psel    = up.psel & mapped & ~bank_sel;
    assign dn0.penable = up.penable;
    assign dn0.pwrite  = up.pwrite;
    assign dn0.paddr   = up.paddr;
    assign dn0.pwdata  = up.pwdata;

    assign dn1.psel    = up.psel & mapped & bank_sel;
    assign dn1.penable = up.penable;
    assign dn1.pwrite  = up.pwrite;
    assign dn1.paddr   = up.paddr;
    assign dn1.pwdata  = up.pwdata;

    // Response mux
    always_comb begin
        if (!mapped) begin
            up.prdata  = {DATA_WIDTH{1'b0}};
            up.pready  = err_rsp;
            up.pslverr = err_rsp;
        end else if (bank_sel) begin
            up.prdata  = dn1.prdata;
            up.pready  = dn1.pready;
            up.pslverr = dn1.pslverr;
        end else begin
            up.prdata  = dn0.prdata;
            up.pready  = dn0.pready;
            up.pslverr = dn0.pslverr;
        end
    end

endmodule

/* design/reg_native_if2apb.sv */
`timescale 1ns/10ps

module reg_native_if2apb #(
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    req_vld,
    output logic                    ack_vld,
    input  logic                    soft_rst,
    input  logic                    wr_en,
    input  logic                    rd_en,
    input  logic [ADDR_WIDTH-1:0]   addr,
    input  logic [DATA_WIDTH-1:0]   wr_data,
    output logic [DATA_WIDTH-1:0]   rd_data,
    output logic                    err,

    apb_if.master                   apb
);
    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_SETUP  = 2'd1,
        S_ACCESS = 2'd2
    } state_t;

    state_t state;
    state_t next_state;
    logic   req_take;

    // A strobe without a direction is ignored
    assign req_take = req_vld & (wr_en | rd_en);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else if (soft_rst) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        if (soft_rst) begin
            next_state = S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_take) begin
                        next_state = S_SETUP;
                    end
                end
                S_SETUP:  next_state = S_ACCESS;
                S_ACCESS: begin
                    // Ack cycle may carry the next request
                    if (apb.pready && req_take) begin
                        next_state = S_SETUP;
                    end else if (apb.pready) begin
                        next_state = S_IDLE;
                    end
                end
                default:  next_state = S_IDLE;
            endcase
        end
    end

    // Request fields captured when entering setup, held through access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            apb.psel   <= 1'b0;
            apb.pwrite <= 1'b0;
            apb.paddr  <= {ADDR_WIDTH{1'b0}};
            apb.pwdata <= {DATA_WIDTH{1'b0}};
        end else if (next_state == S_IDLE) begin
            apb.psel   <= 1'b0;
            apb.pwrite <= 1'b0;
            apb.paddr  <= {ADDR_WIDTH{1'b0}};
            apb.pwdata <= {DATA_WIDTH{1'b0}};
        end else if (next_state == S_SETUP) begin
            apb.psel   <= 1'b1;
            apb.pwrite <= wr_en;
            apb.paddr  <= addr;
            apb.pwdata <= wr_data;
        end
    end

    assign apb.penable = (state == S_ACCESS);

    assign ack_vld = (state == S_ACCESS) & apb.pready;
    assign rd_data = apb.prdata;    // Valid with ack_vld
    assign err     = apb.pslverr;

endmodule

/* design/apb_if.sv */
`timescale 1ns/10ps

interface apb_if #(
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 32
);
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [ADDR_WIDTH-1:0]  paddr;
    logic [DATA_WIDTH-1:0]  pwdata;
    logic [DATA_WIDTH-1:0]  prdata;
    logic                   pready;
    logic                   pslverr;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

/* design/reg_apb_pkg.sv */
package reg_apb_pkg;

    // Word index sits above the byte offset
    parameter int REG_IDX_LSB  = 2;
    parameter int REG_IDX_BITS = 3;    // Eight words per bank

    // Bank select bit with all higher bits zero in mapped space
    parameter int BANK_BIT = 5;

    // Identity word with the bank number in its low byte
    parameter logic [31:0] ID_BASE = 32'h5a1e_0000;

    typedef logic [REG_IDX_BITS-1:0] reg_idx_t;

endpackage
